// File: axi_bridge/axi_bridge.sv
/*
  Single-beat AXI master. Places write data and strobes on the
  byte lanes and pulls read data down to the access size.
*/
module axi_bridge (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              i_start,
  input  rv_bus_pkg::mem_req_t              i_req,
  output logic                              o_done,
  output logic [rv_bus_pkg::DATA_WIDTH-1:0] o_rdata,
  output logic                              o_axi_aw_valid,
  input  logic                              i_axi_aw_ready,
  output rv_bus_pkg::axi_addr_t             o_axi_aw,
  output logic                              o_axi_w_valid,
  input  logic                              i_axi_w_ready,
  output rv_bus_pkg::axi_wdata_t            o_axi_w,
  input  logic                              i_axi_b_valid,
  output logic                              o_axi_b_ready,
  output logic                              o_axi_ar_valid,
  input  logic                              i_axi_ar_ready,
  output rv_bus_pkg::axi_addr_t             o_axi_ar,
  input  logic                              i_axi_r_valid,
  output logic                              o_axi_r_ready,
  input  logic [rv_bus_pkg::DATA_WIDTH-1:0] i_axi_r_data
);

  rv_bus_pkg::bridge_state_e state_q;

  rv_bus_pkg::mem_req_t              req_q;
  logic                              aw_done_q;
  logic                              w_done_q;
  logic                              done_q;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] rdata_q;
  logic                              aw_ok;
  logic                              w_ok;
  logic [5:0]                        shamt;
  logic [rv_bus_pkg::STRB_WIDTH-1:0] strb_base;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] size_mask;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] r_aligned;

  assign shamt = {req_q.addr[2:0], 3'b000};

  // Byte enables and lane mask for the access size
  always_comb begin
    case (req_q.size)
      rv_bus_pkg::SIZE_BYTE: begin
        strb_base = 8'h01;
        size_mask = 64'h0000_0000_0000_00ff;
      end
      rv_bus_pkg::SIZE_HALF: begin
        strb_base = 8'h03;
        size_mask = 64'h0000_0000_0000_ffff;
      end
      rv_bus_pkg::SIZE_WORD: begin
        strb_base = 8'h0f;
        size_mask = 64'h0000_0000_ffff_ffff;
      end
      default: begin
        strb_base = 8'hff;
        size_mask = '1;
      end
    endcase
  end

  assign r_aligned = (i_axi_r_data >> shamt) & size_mask;

  assign o_axi_aw_valid = (state_q == rv_bus_pkg::BR_WRITE) && !aw_done_q;
  assign o_axi_w_valid  = (state_q == rv_bus_pkg::BR_WRITE) && !w_done_q;
  assign o_axi_b_ready  = (state_q == rv_bus_pkg::BR_WRESP);
  assign o_axi_ar_valid = (state_q == rv_bus_pkg::BR_RADDR);
  assign o_axi_r_ready  = (state_q == rv_bus_pkg::BR_RDATA);

  assign o_axi_aw.addr = req_q.addr;
  assign o_axi_aw.size = req_q.size;
  assign o_axi_ar.addr = req_q.addr;
  assign o_axi_ar.size = req_q.size;
  assign o_axi_w.data  = req_q.wdata << shamt;
  assign o_axi_w.strb  = strb_base << req_q.addr[2:0];

  // AW and W finish independently
  assign aw_ok = aw_done_q || (o_axi_aw_valid && i_axi_aw_ready);
  assign w_ok  = w_done_q || (o_axi_w_valid && i_axi_w_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= rv_bus_pkg::BR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        rv_bus_pkg::BR_IDLE: begin
          if (i_start) begin
            state_q <= i_req.wen ? rv_bus_pkg::BR_WRITE : rv_bus_pkg::BR_RADDR;
          end
        end
        rv_bus_pkg::BR_WRITE: begin
          if (aw_ok && w_ok) begin
            state_q   <= rv_bus_pkg::BR_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_ok;
            w_done_q  <= w_ok;
          end
        end
        rv_bus_pkg::BR_WRESP: begin
          if (i_axi_b_valid) begin
            state_q <= rv_bus_pkg::BR_IDLE;
            done_q  <= 1'b1;
          end
        end
        rv_bus_pkg::BR_RADDR: begin
          if (i_axi_ar_ready) begin
            state_q <= rv_bus_pkg::BR_RDATA;
          end
        end
        rv_bus_pkg::BR_RDATA: begin
          if (i_axi_r_valid) begin
            state_q <= rv_bus_pkg::BR_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= rv_bus_pkg::BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == rv_bus_pkg::BR_IDLE && i_start) begin
      req_q <= i_req;
    end
    if (o_axi_r_ready && i_axi_r_valid) begin
      rdata_q <= r_aligned;
    end
  end

  assign o_done  = done_q;
  assign o_rdata = rdata_q;

endmodule

// File: common/rv_bus_pkg.sv
/*
  Bus package for the memory hub.
  Widths, access sizes, request and AXI channel structs, FSM states.
*/
package rv_bus_pkg;

  parameter int ADDR_WIDTH  = 64;
  parameter int DATA_WIDTH  = 64;
  parameter int STRB_WIDTH  = DATA_WIDTH / 8;
  parameter int INSTR_WIDTH = 32;

  // Access size as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } access_size_e;

  // Requester side transfer
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  wen;
    logic [DATA_WIDTH-1:0] wdata;
    access_size_e          size;
  } mem_req_t;

  // Shared by AW and AR
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    access_size_e          size;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } axi_wdata_t;

  typedef enum logic [2:0] {
    BR_IDLE  = 3'd0,
    BR_WRITE = 3'd1,
    BR_WRESP = 3'd2,
    BR_RADDR = 3'd3,
    BR_RDATA = 3'd4
  } bridge_state_e;

  typedef enum logic [1:0] {
    ARB_IDLE      = 2'd0,
    ARB_MEM_LSU   = 2'd1,
    ARB_MEM_FETCH = 2'd2,
    ARB_TIMER     = 2'd3
  } arb_state_e;

endpackage

// File: common/rv_map_pkg.sv
/*
  System address map.
  Location of the machine timer registers.
*/
package rv_map_pkg;

  // CLINT style timer registers of 8 bytes each
  parameter logic [rv_bus_pkg::ADDR_WIDTH-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
  parameter logic [rv_bus_pkg::ADDR_WIDTH-1:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

  // Drops the byte offset inside one register
  parameter logic [rv_bus_pkg::ADDR_WIDTH-1:0] TIMER_SPAN_MASK = ~64'h7;

endpackage

// File: rtl/clint_timer.sv
/*
  Machine timer with a prescaled mtime, mtimecmp and
  a registered timer interrupt.
*/
module clint_timer #(
  parameter int TICK_DIV = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              i_sel,
  input  rv_bus_pkg::mem_req_t              i_req,
  output logic [rv_bus_pkg::DATA_WIDTH-1:0] o_rdata,
  output logic                              o_timer_int
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0]                  div_cnt_q;
  logic                              tick;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] mtime_q;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] mtimecmp_q;
  logic                              timer_int_q;
  logic                              hit_mtime;
  logic                              hit_cmp;
  logic [rv_bus_pkg::ADDR_WIDTH-1:0] reg_addr;

  assign reg_addr  = i_req.addr & rv_map_pkg::TIMER_SPAN_MASK;
  assign hit_mtime = (reg_addr == rv_map_pkg::MTIME_ADDR);
  assign hit_cmp   = (reg_addr == rv_map_pkg::MTIMECMP_ADDR);
  assign tick      = (div_cnt_q == CNT_W'(TICK_DIV - 1));

  // Prescaler
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt_q <= '0;
    end else if (tick) begin
      div_cnt_q <= '0;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // Software write wins over the tick
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime_q <= '0;
    end else if (i_sel && i_req.wen && hit_mtime) begin
      mtime_q <= i_req.wdata;
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp_q <= '1;
    end else if (i_sel && i_req.wen && hit_cmp) begin
      mtimecmp_q <= i_req.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer_int_q <= 1'b0;
    end else begin
      timer_int_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // Full 64-bit reads only
  always_comb begin
    o_rdata = '0;
    if (i_sel && !i_req.wen) begin
      if (hit_mtime) begin
        o_rdata = mtime_q;
      end else if (hit_cmp) begin
        o_rdata = mtimecmp_q;
      end
    end
  end

  assign o_timer_int = timer_int_q;

endmodule

// File: rtl/mem_arbiter.sv
/*
  Memory arbiter. Grants fetch or load/store access with load/store first,
  steers each request to the timer or the AXI bridge and returns the response.
*/
module mem_arbiter (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 i_fetch_valid,
  input  logic [rv_bus_pkg::ADDR_WIDTH-1:0]    i_fetch_addr,
  output logic                                 o_fetch_ready,
  output logic [rv_bus_pkg::INSTR_WIDTH-1:0]   o_fetch_rdata,
  input  logic                                 i_lsu_valid,
  input  rv_bus_pkg::mem_req_t                 i_lsu_req,
  output logic                                 o_lsu_ready,
  output logic [rv_bus_pkg::DATA_WIDTH-1:0]    o_lsu_rdata,
  output logic                                 o_bridge_start,
  output rv_bus_pkg::mem_req_t                 o_bridge_req,
  input  logic                                 i_bridge_done,
  input  logic [rv_bus_pkg::DATA_WIDTH-1:0]    i_bridge_rdata,
  output logic                                 o_timer_sel,
  output rv_bus_pkg::mem_req_t                 o_timer_req,
  input  logic [rv_bus_pkg::DATA_WIDTH-1:0]    i_timer_rdata
);

  rv_bus_pkg::arb_state_e state_q, state_d;

  logic                              lsu_ready_q;
  logic                              fetch_ready_q;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] rdata_q;
  logic                              lsu_go;
  logic                              fetch_go;
  logic                              lsu_is_timer;
  logic                              idle;
  rv_bus_pkg::mem_req_t              fetch_req;

  // Fetch is always a word read
  always_comb begin
    fetch_req       = '0;
    fetch_req.addr  = i_fetch_addr;
    fetch_req.wen   = 1'b0;
    fetch_req.size  = rv_bus_pkg::SIZE_WORD;
  end

  // A port whose ready is high still shows the finished request
  assign lsu_go   = i_lsu_valid && !lsu_ready_q;
  assign fetch_go = i_fetch_valid && !fetch_ready_q;
  assign idle     = (state_q == rv_bus_pkg::ARB_IDLE);

  assign lsu_is_timer =
    ((i_lsu_req.addr & rv_map_pkg::TIMER_SPAN_MASK) == rv_map_pkg::MTIMECMP_ADDR) ||
    ((i_lsu_req.addr & rv_map_pkg::TIMER_SPAN_MASK) == rv_map_pkg::MTIME_ADDR);

  assign o_timer_sel    = idle && lsu_go && lsu_is_timer;
  assign o_timer_req    = i_lsu_req;
  assign o_bridge_start = idle && ((lsu_go && !lsu_is_timer) || (!lsu_go && fetch_go));
  assign o_bridge_req   = lsu_go ? i_lsu_req : fetch_req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_bus_pkg::ARB_IDLE: begin
        if (lsu_go) begin
          state_d = lsu_is_timer ? rv_bus_pkg::ARB_TIMER : rv_bus_pkg::ARB_MEM_LSU;
        end else if (fetch_go) begin
          state_d = rv_bus_pkg::ARB_MEM_FETCH;
        end
      end
      rv_bus_pkg::ARB_MEM_LSU,
      rv_bus_pkg::ARB_MEM_FETCH: begin
        if (i_bridge_done) begin
          state_d = rv_bus_pkg::ARB_IDLE;
        end
      end
      // Timer answer goes out in this cycle
      rv_bus_pkg::ARB_TIMER: state_d = rv_bus_pkg::ARB_IDLE;
      default: state_d = rv_bus_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= rv_bus_pkg::ARB_IDLE;
      lsu_ready_q   <= 1'b0;
      fetch_ready_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      lsu_ready_q   <= o_timer_sel ||
                       (state_q == rv_bus_pkg::ARB_MEM_LSU && i_bridge_done);
      fetch_ready_q <= (state_q == rv_bus_pkg::ARB_MEM_FETCH) && i_bridge_done;
    end
  end

  always_ff @(posedge clk) begin
    if (o_timer_sel) begin
      rdata_q <= i_timer_rdata;
    end else if (i_bridge_done) begin
      rdata_q <= i_bridge_rdata;
    end
  end

  assign o_lsu_ready   = lsu_ready_q;
  assign o_fetch_ready = fetch_ready_q;
  assign o_lsu_rdata   = rdata_q;
  assign o_fetch_rdata = rdata_q[rv_bus_pkg::INSTR_WIDTH-1:0];

endmodule

// File: rtl/rv_mem_hub.sv
/*
  Memory hub top. Fetch and load/store ports share
  one AXI master and the machine timer.
*/
module rv_mem_hub #(
  parameter int TIMER_TICK_DIV = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_fetch_valid,
  input  logic [rv_bus_pkg::ADDR_WIDTH-1:0]  i_fetch_addr,
  output logic                               o_fetch_ready,
  output logic [rv_bus_pkg::INSTR_WIDTH-1:0] o_fetch_rdata,
  input  logic                               i_lsu_valid,
  input  rv_bus_pkg::mem_req_t               i_lsu_req,
  output logic                               o_lsu_ready,
  output logic [rv_bus_pkg::DATA_WIDTH-1:0]  o_lsu_rdata,
  output logic                               o_axi_aw_valid,
  input  logic                               i_axi_aw_ready,
  output rv_bus_pkg::axi_addr_t              o_axi_aw,
  output logic                               o_axi_w_valid,
  input  logic                               i_axi_w_ready,
  output rv_bus_pkg::axi_wdata_t             o_axi_w,
  input  logic                               i_axi_b_valid,
  output logic                               o_axi_b_ready,
  output logic                               o_axi_ar_valid,
  input  logic                               i_axi_ar_ready,
  output rv_bus_pkg::axi_addr_t              o_axi_ar,
  input  logic                               i_axi_r_valid,
  output logic                               o_axi_r_ready,
  input  logic [rv_bus_pkg::DATA_WIDTH-1:0]  i_axi_r_data,
  output logic                               o_timer_int
);

  logic                              bridge_start;
  rv_bus_pkg::mem_req_t              bridge_req;
  logic                              bridge_done;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] bridge_rdata;
  logic                              timer_sel;
  rv_bus_pkg::mem_req_t              timer_req;
  logic [rv_bus_pkg::DATA_WIDTH-1:0] timer_rdata;

  mem_arbiter u_mem_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_fetch_valid  (i_fetch_valid),
    .i_fetch_addr   (i_fetch_addr),
    .o_fetch_ready  (o_fetch_ready),
    .o_fetch_rdata  (o_fetch_rdata),
    .i_lsu_valid    (i_lsu_valid),
    .i_lsu_req      (i_lsu_req),
    .o_lsu_ready    (o_lsu_ready),
    .o_lsu_rdata    (o_lsu_rdata),
    .o_bridge_start (bridge_start),
    .o_bridge_req   (bridge_req),
    .i_bridge_done  (bridge_done),
    .i_bridge_rdata (bridge_rdata),
    .o_timer_sel    (timer_sel),
    .o_timer_req    (timer_req),
    .i_timer_rdata  (timer_rdata)
  );

  clint_timer #(
    .TICK_DIV (TIMER_TICK_DIV)
  ) u_clint_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sel       (timer_sel),
    .i_req       (timer_req),
    .o_rdata     (timer_rdata),
    .o_timer_int (o_timer_int)
  );

  axi_bridge u_axi_bridge (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_start        (bridge_start),
    .i_req          (bridge_req),
    .o_done         (bridge_done),
    .o_rdata        (bridge_rdata),
    .o_axi_aw_valid (o_axi_aw_valid),
    .i_axi_aw_ready (i_axi_aw_ready),
    .o_axi_aw       (o_axi_aw),
    .o_axi_w_valid  (o_axi_w_valid),
    .i_axi_w_ready  (i_axi_w_ready),
    .o_axi_w        (o_axi_w),
    .i_axi_b_valid  (i_axi_b_valid),
    .o_axi_b_ready  (o_axi_b_ready),
    .o_axi_ar_valid (o_axi_ar_valid),
    .i_axi_ar_ready (i_axi_ar_ready),
    .o_axi_ar       (o_axi_ar),
    .i_axi_r_valid  (i_axi_r_valid),
    .o_axi_r_ready  (o_axi_r_ready),
    .i_axi_r_data   (i_axi_r_data)
  );

endmodule

// File: rv_mem_hub.f
common/rv_bus_pkg.sv
common/rv_map_pkg.sv
rtl/mem_arbiter.sv
rtl/clint_timer.sv
axi_bridge/axi_bridge.sv
rtl/rv_mem_hub.sv
verification/tb_clk_gen.sv
verification/axi_mem_model.sv
verification/rv_mem_hub_tb.sv

// File: verification/axi_mem_model.sv
/*
  AXI slave memory with random ready delays.
  Flags any payload that changes before its handshake.
*/
module axi_mem_model (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              i_aw_valid,
  output logic                              o_aw_ready,
  input  rv_bus_pkg::axi_addr_t             i_aw,
  input  logic                              i_w_valid,
  output logic                              o_w_ready,
  input  rv_bus_pkg::axi_wdata_t            i_w,
  output logic                              o_b_valid,
  input  logic                              i_b_ready,
  input  logic                              i_ar_valid,
  output logic                              o_ar_ready,
  input  rv_bus_pkg::axi_addr_t             i_ar,
  output logic                              o_r_valid,
  input  logic                              i_r_ready,
  output logic [rv_bus_pkg::DATA_WIDTH-1:0] o_r_data,
  output logic [rv_bus_pkg::STRB_WIDTH-1:0] o_last_strb,
  output rv_bus_pkg::axi_addr_t             o_last_aw,
  output rv_bus_pkg::axi_addr_t             o_last_ar,
  output logic                              o_proto_err
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] mem [logic [63:0]];

  logic [1:0]  aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt;
  logic        aw_got, w_got, b_pend, r_pend;
  rv_bus_pkg::axi_wdata_t w_q;
  logic        p_aw_valid, p_aw_hs, p_w_valid, p_w_hs, p_ar_valid, p_ar_hs;
  rv_bus_pkg::axi_addr_t  p_aw, p_ar;
  rv_bus_pkg::axi_wdata_t p_w;

  function automatic logic [7:0] read_byte(input logic [63:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return 8'(a * 7 + 3);
  endfunction

  function automatic logic [63:0] read_beat(input logic [63:0] a);
    logic [63:0] base;
    logic [63:0] v;
    base = {a[63:3], 3'b000};
    for (int i = 0; i < 8; i++) begin
      v[8*i +: 8] = read_byte(base + i);
    end
    return v;
  endfunction

  initial begin
    void'($urandom(43));
    o_aw_ready  = 1'b0;
    o_w_ready   = 1'b0;
    o_b_valid   = 1'b0;
    o_ar_ready  = 1'b0;
    o_r_valid   = 1'b0;
    o_r_data    = '0;
    o_last_strb = '0;
    o_last_aw   = '0;
    o_last_ar   = '0;
    o_proto_err = 1'b0;
    aw_cnt      = 0;
    w_cnt       = 0;
    b_cnt       = 0;
    ar_cnt      = 0;
    r_cnt       = 0;
    aw_got      = 0;
    w_got       = 0;
    b_pend      = 0;
    r_pend      = 0;
    p_aw_valid  = 0;
    p_aw_hs     = 0;
    p_w_valid   = 0;
    p_w_hs      = 0;
    p_ar_valid  = 0;
    p_ar_hs     = 0;
  end

  // AW and W in any order, then B
  always @(posedge clk) begin
    if (rst_n) begin
      if (o_aw_ready && i_aw_valid) begin
        o_aw_ready <= 1'b0;
        o_last_aw  <= i_aw;
        aw_got     <= 1'b1;
      end else if (i_aw_valid && !o_aw_ready && !aw_got) begin
        if (aw_cnt == 0) begin
          o_aw_ready <= 1'b1;
          aw_cnt     <= $urandom % 4;
        end else begin
          aw_cnt <= aw_cnt - 1;
        end
      end
      if (o_w_ready && i_w_valid) begin
        o_w_ready <= 1'b0;
        w_q       <= i_w;
        w_got     <= 1'b1;
      end else if (i_w_valid && !o_w_ready && !w_got) begin
        if (w_cnt == 0) begin
          o_w_ready <= 1'b1;
          w_cnt     <= $urandom % 4;
        end else begin
          w_cnt <= w_cnt - 1;
        end
      end
      if (aw_got && w_got && !b_pend) begin
        for (int i = 0; i < 8; i++) begin
          if (w_q.strb[i]) begin
            mem[{o_last_aw.addr[63:3], 3'b000} + i] = w_q.data[8*i +: 8];
          end
        end
        o_last_strb <= w_q.strb;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_pend <= 1'b1;
        b_cnt  <= $urandom % 4;
      end
      if (o_b_valid && i_b_ready) begin
        o_b_valid <= 1'b0;
        b_pend    <= 1'b0;
      end else if (b_pend && !o_b_valid) begin
        if (b_cnt == 0) begin
          o_b_valid <= 1'b1;
        end else begin
          b_cnt <= b_cnt - 1;
        end
      end
    end
  end

  // Read side
  always @(posedge clk) begin
    if (rst_n) begin
      if (o_ar_ready && i_ar_valid) begin
        o_ar_ready <= 1'b0;
        o_last_ar  <= i_ar;
        r_pend     <= 1'b1;
        r_cnt      <= $urandom % 4;
      end else if (i_ar_valid && !o_ar_ready && !r_pend) begin
        if (ar_cnt == 0) begin
          o_ar_ready <= 1'b1;
          ar_cnt     <= $urandom % 4;
        end else begin
          ar_cnt <= ar_cnt - 1;
        end
      end
      if (o_r_valid && i_r_ready) begin
        o_r_valid <= 1'b0;
        r_pend    <= 1'b0;
      end else if (r_pend && !o_r_valid) begin
        if (r_cnt == 0) begin
          o_r_valid <= 1'b1;
          o_r_data  <= read_beat(o_last_ar.addr);
        end else begin
          r_cnt <= r_cnt - 1;
        end
      end
    end
  end

  // Payload stability until handshake
  always @(posedge clk) begin
    if (p_aw_valid && !p_aw_hs) begin
      assert (i_aw_valid && i_aw == p_aw) else begin
        $display("AW valid or payload changed before its handshake");
        o_proto_err <= 1'b1;
      end
    end
    if (p_w_valid && !p_w_hs) begin
      assert (i_w_valid && i_w == p_w) else begin
        $display("W valid or payload changed before its handshake");
        o_proto_err <= 1'b1;
      end
    end
    if (p_ar_valid && !p_ar_hs) begin
      assert (i_ar_valid && i_ar == p_ar) else begin
        $display("AR valid or payload changed before its handshake");
        o_proto_err <= 1'b1;
      end
    end
    p_aw_valid <= i_aw_valid;
    p_aw_hs    <= i_aw_valid && o_aw_ready;
    p_aw       <= i_aw;
    p_w_valid  <= i_w_valid;
    p_w_hs     <= i_w_valid && o_w_ready;
    p_w        <= i_w;
    p_ar_valid <= i_ar_valid;
    p_ar_hs    <= i_ar_valid && o_ar_ready;
    p_ar       <= i_ar;
  end

endmodule

// File: verification/rv_mem_hub_tb.sv
/*
  Table driven testbench for the memory hub
*/
module rv_mem_hub_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;
  localparam logic [63:0] BASE = 64'h8000_1000;

  typedef struct packed {
    logic                     is_fetch;
    logic                     to_timer;
    logic [63:0]              addr;
    logic                     wen;
    logic [63:0]              wdata;
    rv_bus_pkg::access_size_e size;
    logic                     with_fetch;
    logic [63:0]              faddr;
    logic                     check;
    logic [63:0]              exp;
    logic [31:0]              fexp;
  } entry_t;

  logic clk, rst_n;
  logic i_fetch_valid, o_fetch_ready, i_lsu_valid, o_lsu_ready, o_timer_int;
  logic [63:0] i_fetch_addr, o_lsu_rdata;
  logic [31:0] o_fetch_rdata;
  rv_bus_pkg::mem_req_t   i_lsu_req;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  rv_bus_pkg::axi_addr_t  aw, ar;
  rv_bus_pkg::axi_wdata_t w;
  logic [63:0] r_data;
  logic [7:0]  last_strb;
  rv_bus_pkg::axi_addr_t  last_aw, last_ar;
  logic        proto_err;
  logic        timer_phase;

  entry_t      table_q[$];
  logic [7:0]  shadow [logic [63:0]];
  entry_t      e;
  logic [63:0] got, t0, t1;
  int          cyc;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  rv_mem_hub #(.TIMER_TICK_DIV(2)) rv_mem_hub_i (
    .clk(clk), .rst_n(rst_n),
    .i_fetch_valid(i_fetch_valid), .i_fetch_addr(i_fetch_addr),
    .o_fetch_ready(o_fetch_ready), .o_fetch_rdata(o_fetch_rdata),
    .i_lsu_valid(i_lsu_valid), .i_lsu_req(i_lsu_req),
    .o_lsu_ready(o_lsu_ready), .o_lsu_rdata(o_lsu_rdata),
    .o_axi_aw_valid(aw_valid), .i_axi_aw_ready(aw_ready), .o_axi_aw(aw),
    .o_axi_w_valid(w_valid), .i_axi_w_ready(w_ready), .o_axi_w(w),
    .i_axi_b_valid(b_valid), .o_axi_b_ready(b_ready),
    .o_axi_ar_valid(ar_valid), .i_axi_ar_ready(ar_ready), .o_axi_ar(ar),
    .i_axi_r_valid(r_valid), .o_axi_r_ready(r_ready), .i_axi_r_data(r_data),
    .o_timer_int(o_timer_int)
  );

  axi_mem_model u_mem (
    .clk(clk), .rst_n(rst_n),
    .i_aw_valid(aw_valid), .o_aw_ready(aw_ready), .i_aw(aw),
    .i_w_valid(w_valid), .o_w_ready(w_ready), .i_w(w),
    .o_b_valid(b_valid), .i_b_ready(b_ready),
    .i_ar_valid(ar_valid), .o_ar_ready(ar_ready), .i_ar(ar),
    .o_r_valid(r_valid), .i_r_ready(r_ready), .o_r_data(r_data),
    .o_last_strb(last_strb), .o_last_aw(last_aw), .o_last_ar(last_ar),
    .o_proto_err(proto_err)
  );

  task automatic fail_now();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg, input logic [63:0] act,
                                 input logic [63:0] want);
    $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, act, want);
    fail_now();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    fail_now();
  endtask

  // Written bytes from the shadow, others from the fill rule
  function automatic logic [63:0] ref_read(input logic [63:0] a, input int n);
    logic [63:0] v;
    logic [63:0] ba;
    v = '0;
    for (int i = 0; i < n; i++) begin
      ba = a + i;
      v[8*i +: 8] = shadow.exists(ba) ? shadow[ba] : 8'(ba * 7 + 3);
    end
    return v;
  endfunction

  function automatic logic [7:0] ref_strb(input logic [63:0] a, input int n);
    logic [7:0] s;
    s = '0;
    for (int i = 0; i < n; i++) begin
      s[a[2:0] + i] = 1'b1;
    end
    return s;
  endfunction

  task automatic add_lsu(input logic [63:0] a, input logic wr, input logic [63:0] d,
                         input rv_bus_pkg::access_size_e sz, input logic wf,
                         input logic [63:0] fa);
    entry_t x;
    int n;
    n = 1 << sz;
    x = '0;
    x.addr = a;
    x.wen = wr;
    x.wdata = d;
    x.size = sz;
    x.check = 1'b1;
    if (wr) begin
      for (int i = 0; i < n; i++) begin
        shadow[a + i] = d[8*i +: 8];
      end
    end else begin
      x.exp = ref_read(a, n);
    end
    x.with_fetch = wf;
    x.faddr = fa;
    // Load/store wins, so the fetch sees its write
    x.fexp = ref_read(fa, 4);
    table_q.push_back(x);
  endtask

  task automatic add_fetch(input logic [63:0] a);
    entry_t x;
    x = '0;
    x.is_fetch = 1'b1;
    x.faddr = a;
    x.check = 1'b1;
    x.fexp = ref_read(a, 4);
    table_q.push_back(x);
  endtask

  task automatic run_entry(input entry_t x, output logic [63:0] rd);
    logic lsu_pend;
    logic f_pend;
    int n;
    int lsu_at;
    int f_at;
    logic [31:0] frd;
    rv_bus_pkg::axi_addr_t lsu_ax;
    rv_bus_pkg::axi_addr_t f_ax;
    lsu_pend = !x.is_fetch;
    f_pend = x.is_fetch || x.with_fetch;
    n = 0;
    lsu_at = 0;
    f_at = 0;
    frd = '0;
    lsu_ax = '0;
    f_ax = '0;
    rd = '0;
    @(posedge clk);
    if (lsu_pend) begin
      i_lsu_valid <= 1'b1;
      i_lsu_req <= '{addr: x.addr, wen: x.wen, wdata: x.wdata, size: x.size};
    end
    if (f_pend) begin
      i_fetch_valid <= 1'b1;
      i_fetch_addr <= x.faddr;
    end
    while (lsu_pend || f_pend) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        report_timeout(lsu_pend ? "load/store ready" : "fetch ready");
      end
      if (lsu_pend && o_lsu_ready) begin
        i_lsu_valid <= 1'b0;
        lsu_pend = 1'b0;
        lsu_at = n;
        rd = o_lsu_rdata;
        lsu_ax = x.wen ? last_aw : last_ar;
      end
      if (f_pend && o_fetch_ready) begin
        i_fetch_valid <= 1'b0;
        f_pend = 1'b0;
        f_at = n;
        frd = o_fetch_rdata;
        f_ax = last_ar;
      end
    end
    if (x.check && !x.is_fetch && !x.wen) begin
      assert (rd == x.exp) else report_mismatch("load data", rd, x.exp);
    end
    if (x.check && !x.is_fetch && x.wen) begin
      assert (last_strb == ref_strb(x.addr, 1 << x.size))
        else report_mismatch("write strobes", last_strb, ref_strb(x.addr, 1 << x.size));
    end
    if (x.check && !x.is_fetch && !x.to_timer) begin
      assert (lsu_ax.addr == x.addr)
        else report_mismatch("AXI address", lsu_ax.addr, x.addr);
      assert (lsu_ax.size == x.size)
        else report_mismatch("AXI size", lsu_ax.size, x.size);
    end
    if (x.is_fetch || x.with_fetch) begin
      assert (frd == x.fexp) else report_mismatch("fetch data", frd, x.fexp);
      assert (f_ax.addr == x.faddr)
        else report_mismatch("fetch AXI address", f_ax.addr, x.faddr);
      assert (f_ax.size == rv_bus_pkg::SIZE_WORD)
        else report_mismatch("fetch AXI size", f_ax.size, rv_bus_pkg::SIZE_WORD);
    end
    if (x.with_fetch) begin
      assert (lsu_at < f_at) else report_mismatch("ready order", f_at, lsu_at);
    end
  endtask

  task automatic timer_access(input logic [63:0] a, input logic wr, input logic [63:0] d,
                              output logic [63:0] rd);
    entry_t x;
    x = '0;
    x.to_timer = 1'b1;
    x.addr = a;
    x.wen = wr;
    x.wdata = d;
    x.size = rv_bus_pkg::SIZE_DOUBLE;
    run_entry(x, rd);
  endtask

  always @(posedge clk) begin
    assert (!proto_err) else begin
      $display("AXI slave model reported a protocol error");
      fail_now();
    end
    if (timer_phase) begin
      assert (!(aw_valid || w_valid || ar_valid)) else begin
        $display("AXI valid raised during a timer access");
        fail_now();
      end
    end
  end

  initial begin
    i_fetch_valid = 1'b0;
    i_fetch_addr  = '0;
    i_lsu_valid   = 1'b0;
    i_lsu_req     = '0;
    timer_phase   = 1'b0;

    // First table entry reads the mtimecmp reset value
    e = '0;
    e.to_timer = 1'b1;
    e.addr = rv_map_pkg::MTIMECMP_ADDR;
    e.size = rv_bus_pkg::SIZE_DOUBLE;
    e.check = 1'b1;
    e.exp = '1;
    table_q.push_back(e);
    add_lsu(BASE, 1, 64'h1122_3344_5566_7788, rv_bus_pkg::SIZE_DOUBLE, 0, 0);
    add_lsu(BASE + 3, 1, 64'hAB, rv_bus_pkg::SIZE_BYTE, 0, 0);
    add_lsu(BASE + 6, 1, 64'hBEEF, rv_bus_pkg::SIZE_HALF, 0, 0);
    add_lsu(BASE + 8, 1, 64'hCAFE_F00D, rv_bus_pkg::SIZE_WORD, 0, 0);
    add_lsu(BASE + 23, 1, 64'h5A, rv_bus_pkg::SIZE_BYTE, 0, 0);
    add_lsu(BASE, 0, 0, rv_bus_pkg::SIZE_DOUBLE, 0, 0);
    add_lsu(BASE + 3, 0, 0, rv_bus_pkg::SIZE_BYTE, 0, 0);
    add_lsu(BASE + 6, 0, 0, rv_bus_pkg::SIZE_HALF, 0, 0);
    add_lsu(BASE + 4, 0, 0, rv_bus_pkg::SIZE_WORD, 0, 0);
    add_lsu(BASE + 8, 0, 0, rv_bus_pkg::SIZE_WORD, 0, 0);
    add_lsu(BASE + 10, 0, 0, rv_bus_pkg::SIZE_HALF, 0, 0);
    add_lsu(BASE + 23, 0, 0, rv_bus_pkg::SIZE_BYTE, 0, 0);
    add_lsu(BASE + 16, 0, 0, rv_bus_pkg::SIZE_DOUBLE, 0, 0);
    add_lsu(BASE + 18, 0, 0, rv_bus_pkg::SIZE_HALF, 0, 0);
    add_lsu(BASE + 32, 0, 0, rv_bus_pkg::SIZE_WORD, 0, 0);
    add_fetch(BASE);
    add_fetch(BASE + 8);
    add_fetch(BASE + 64'h1000);
    add_lsu(BASE + 8, 0, 0, rv_bus_pkg::SIZE_DOUBLE, 1, BASE + 4);
    add_lsu(BASE + 48, 1, 64'h0BAD_C0DE, rv_bus_pkg::SIZE_WORD, 1, BASE + 48);

    cyc = 0;
    while (!rst_n) begin
      @(posedge clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        report_timeout("reset release");
      end
    end
    @(posedge clk);
    assert (!(aw_valid || w_valid || b_ready || ar_valid || r_ready ||
              o_lsu_ready || o_fetch_ready || o_timer_int))
      else report_mismatch("outputs after reset", 1, 0);

    foreach (table_q[i]) begin
      run_entry(table_q[i], got);
    end

    // Timer checks
    timer_phase = 1'b1;
    timer_access(rv_map_pkg::MTIME_ADDR, 0, 0, t0);
    timer_access(rv_map_pkg::MTIME_ADDR, 0, 0, t1);
    assert (t1 >= t0) else report_mismatch("mtime decreased", t1, t0);
    timer_access(rv_map_pkg::MTIMECMP_ADDR, 1, t1 + 10, got);
    timer_phase = 1'b0;
    cyc = 0;
    while (!o_timer_int) begin
      @(posedge clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        report_timeout("timer interrupt to rise");
      end
    end
    timer_phase = 1'b1;
    timer_access(rv_map_pkg::MTIMECMP_ADDR, 1, '1, got);
    timer_phase = 1'b0;
    cyc = 0;
    while (o_timer_int) begin
      @(posedge clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        report_timeout("timer interrupt to fall");
      end
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: verification/tb_clk_gen.sv
/*
  Clock and reset source for the testbench
*/
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #20 clk = ~clk;

endmodule
